// File: hw/sata_fis_pkg.sv
// sata fis buffer shared definitions
// payload word, per-direction tag encodings and fill-level thresholds

package sata_fis_pkg;

    // one payload dword as carried through both FIFOs
    typedef logic [31:0] dword_t;

    localparam int TAG_W       = 2;              // width of the type tag
    localparam int FIFO_WORD_W = TAG_W + 32;     // tag plus dword in each FIFO entry

    // host to device tags, written by the host with each word
    typedef enum logic [TAG_W-1:0] {
        h2d_data = 2'd0,                         // FIS body word
        h2d_head = 2'd1,                         // first word of a FIS
        h2d_last = 2'd2                          // final word of a FIS
    } h2d_type_e;

    // device to host tags, produced by the tagger
    typedef enum logic [TAG_W-1:0] {
        d2h_dma      = 2'd0,                     // body word
        d2h_fis_head = 2'd1,                     // first word of a FIS
        d2h_ok       = 2'd2,                     // good frame marker, data ignored
        d2h_err      = 2'd3                      // bad frame marker, data ignored
    } d2h_type_e;

    // d2h_many threshold, also the h2d headroom below full
    localparam int MANY_WORDS = 8;

    // link is told busy when fewer d2h entries than this are free
    localparam int BUSY_MARGIN = 64;

endpackage

// File: hw/fis_fifo.sv
// fis fifo
// same-clock first-word-fall-through FIFO with fill count, tag plus dword per entry
`timescale 1ns/1ns

module fis_fifo import sata_fis_pkg::*; #(
    parameter int FIFO_ADDR_W = 9                // depth is 2**FIFO_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,        // synchronous empty, keeps memory contents
    input  logic                   wr,           // push wr_data this cycle
    input  logic [FIFO_WORD_W-1:0] wr_data,
    input  logic                   rd,           // pop head word, ignored when empty
    output logic [FIFO_WORD_W-1:0] rd_data,      // head word, valid while nempty
    output logic                   nempty,
    output logic [FIFO_ADDR_W:0]   fill          // number of stored words
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    logic [FIFO_WORD_W-1:0] mem [0:DEPTH-1];     // storage array
    logic [FIFO_ADDR_W-1:0] wr_ptr;              // next slot to write
    logic [FIFO_ADDR_W-1:0] rd_ptr;              // current head slot
    logic                   full;
    logic                   wr_en;               // qualified push
    logic                   rd_en;               // qualified pop

    assign full   = fill[FIFO_ADDR_W];           // fill == DEPTH
    assign nempty = |fill;
    assign wr_en  = wr && !full;                 // push into a full FIFO is dropped
    assign rd_en  = rd && nempty;                // pop from empty is ignored

    // head word falls through straight from the array
    assign rd_data = mem[rd_ptr];

    // payload storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers and fill count
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;         // wraps at DEPTH
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;    // push only
                2'b01:   fill <= fill - 1'b1;    // pop only
                default: fill <= fill;           // none, or both at once
            endcase
        end
    end

endmodule

// File: hw/h2d_frame_starter.sv
// h2d frame starter
// requests a frame transmission once a FIS is fully buffered or enough words wait
`timescale 1ns/1ns

module h2d_frame_starter import sata_fis_pkg::*; #(
    parameter int FIFO_ADDR_W = 9,               // width of the fill count is FIFO_ADDR_W+1
    parameter int START_BITS  = 6                // start once 2**START_BITS words are buffered
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,             // host word written to the h2d FIFO
    input  h2d_type_e            wr_type,        // tag of the word being written
    input  logic [FIFO_ADDR_W:0] fill,           // h2d FIFO fill count
    input  logic                 frame_ack,      // link accepted the request
    output logic                 frame_req       // request a new frame transmission
);

    logic pending;                               // a FIS head went in, no request yet
    logic head_wr;
    logic last_wr;
    logic enough_words;                          // start threshold reached

    assign head_wr = wr && (wr_type == h2d_head);
    assign last_wr = wr && (wr_type == h2d_last);

    // any bit at or above START_BITS means fill >= 2**START_BITS
    assign enough_words = |fill[FIFO_ADDR_W:START_BITS];

    // pending FIS, dropped as soon as the request is seen
    always_ff @(posedge clk) begin
        if (rst || frame_req) begin
            pending <= 1'b0;
        end else if (head_wr) begin
            pending <= 1'b1;
        end
    end

    // request register, held until the link acknowledges
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_req <= 1'b0;
        end else if (pending && (last_wr || enough_words)) begin
            frame_req <= 1'b1;                   // whole FIS in, or enough to stream
        end else if (frame_ack) begin
            frame_req <= 1'b0;
        end
    end

endmodule

// File: hw/d2h_fis_tagger.sv
// d2h fis tagger
// tags words from the link as head or body, appends one OK/ERR marker per frame
`timescale 1ns/1ns

module d2h_fis_tagger import sata_fis_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      incom_start,               // link began receiving a frame
    input  logic      incom_done,                // frame completed good
    input  logic      incom_invalidate,          // frame had errors
    input  logic      word_valid,                // link delivers a word
    input  dword_t    word_data,
    output logic      fifo_wr,                   // write strobe into the d2h FIFO
    output d2h_type_e fifo_type,
    output dword_t    fifo_data
);

    d2h_type_e cur_type;                         // tag for the next write
    logic      invalidate_r;                     // invalidate one cycle late
    logic      marker_push;                      // push the end-of-frame marker
    logic      frame_end;

    // late invalidate lets a final data word arriving with it pass as body
    always_ff @(posedge clk) begin
        if (rst) begin
            invalidate_r <= 1'b0;
        end else begin
            invalidate_r <= incom_invalidate;
        end
    end

    assign frame_end = incom_done || invalidate_r;

    // tag state: head after start, body after first word, marker at end
    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            cur_type <= d2h_fis_head;
        end else if (word_valid) begin
            cur_type <= d2h_dma;
        end else if (frame_end) begin
            cur_type <= invalidate_r ? d2h_err : d2h_ok;
        end
    end

    // only one marker, and only after at least one body word
    always_ff @(posedge clk) begin
        if (rst) begin
            marker_push <= 1'b0;
        end else begin
            marker_push <= frame_end && (cur_type == d2h_dma);
        end
    end

    // link words and marker share one write port
    assign fifo_wr   = word_valid || marker_push;
    assign fifo_type = cur_type;
    assign fifo_data = marker_push ? '0 : word_data;  // marker carries no payload

endmodule

// File: hw/sata_fis_buffer.sv
// sata fis buffer top
// host/link FIFOs in both directions with frame start control and fill-level flags
`timescale 1ns/1ns

module sata_fis_buffer import sata_fis_pkg::*; #(
    parameter int FIFO_ADDR_W = 9,               // FIFO depth is 2**FIFO_ADDR_W
    parameter int START_BITS  = 6                // h2d start threshold is 2**START_BITS words
) (
    input  logic      clk,
    input  logic      rst,

    // host side, host to device
    input  dword_t    h2d_data,
    input  h2d_type_e h2d_type,
    input  logic      h2d_valid,                 // write every valid cycle
    output logic      h2d_ready,                 // room for at least MANY_WORDS more

    // link side, host to device
    output dword_t    ll_h2d_data,
    output logic      ll_h2d_last,               // head word is the last of its FIS
    output logic      ll_h2d_valid,              // h2d FIFO not empty
    input  logic      ll_h2d_strobe,             // link consumes head word
    output logic      ll_frame_req,
    input  logic      ll_frame_ack,

    // link side, device to host
    input  dword_t    ll_d2h_data,
    input  logic      ll_d2h_valid,
    input  logic      ll_incom_start,
    input  logic      ll_incom_done,
    input  logic      ll_incom_invalidate,
    output logic      ll_d2h_busy,               // link must pause sending

    // host side, device to host
    output dword_t    d2h_data,
    output d2h_type_e d2h_type,
    output logic      d2h_valid,
    output logic      d2h_many,                  // MANY_WORDS or more unread
    input  logic      d2h_ready,

    input  logic      pcmd_st_cleared            // software stop, flushes both FIFOs
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    // flag thresholds sized to the fill count
    localparam logic [FIFO_ADDR_W:0] DEPTH_V = (FIFO_ADDR_W+1)'(DEPTH);
    localparam logic [FIFO_ADDR_W:0] READY_V = (FIFO_ADDR_W+1)'(DEPTH - MANY_WORDS);
    localparam logic [FIFO_ADDR_W:0] MANY_V  = (FIFO_ADDR_W+1)'(MANY_WORDS);
    localparam logic [FIFO_ADDR_W:0] BUSY_V  = (FIFO_ADDR_W+1)'(BUSY_MARGIN);

    logic [FIFO_WORD_W-1:0] h2d_rd_word;         // h2d head entry, tag and data
    logic [FIFO_ADDR_W:0]   h2d_fill;
    logic                   h2d_nempty;
    h2d_type_e              h2d_head_type;

    logic [FIFO_WORD_W-1:0] d2h_rd_word;         // d2h head entry, tag and data
    logic [FIFO_ADDR_W:0]   d2h_fill;
    logic [FIFO_ADDR_W:0]   d2h_free;            // unused d2h entries
    logic                   d2h_nempty;
    logic                   d2h_rd;

    logic                   d2h_wr;              // tagger write stream
    d2h_type_e              d2h_wr_type;
    dword_t                 d2h_wr_data;

    // host to device path
    fis_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) h2d_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .flush   (pcmd_st_cleared),
        .wr      (h2d_valid),                    // host only asserts valid with ready
        .wr_data ({h2d_type, h2d_data}),
        .rd      (ll_h2d_strobe),                // strobe on empty is dropped inside
        .rd_data (h2d_rd_word),
        .nempty  (h2d_nempty),
        .fill    (h2d_fill)
    );

    h2d_frame_starter #(
        .FIFO_ADDR_W (FIFO_ADDR_W),
        .START_BITS  (START_BITS)
    ) starter_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),
        .wr_type   (h2d_type),
        .fill      (h2d_fill),
        .frame_ack (ll_frame_ack),
        .frame_req (ll_frame_req)
    );

    assign h2d_head_type = h2d_type_e'(h2d_rd_word[FIFO_WORD_W-1:32]);
    assign ll_h2d_data   = h2d_rd_word[31:0];
    assign ll_h2d_last   = (h2d_head_type == h2d_last);
    assign ll_h2d_valid  = h2d_nempty;
    assign h2d_ready     = (h2d_fill < READY_V); // keep MANY_WORDS of headroom

    // device to host path
    d2h_fis_tagger tagger_i (
        .clk              (clk),
        .rst              (rst),
        .incom_start      (ll_incom_start),
        .incom_done       (ll_incom_done),
        .incom_invalidate (ll_incom_invalidate),
        .word_valid       (ll_d2h_valid),
        .word_data        (ll_d2h_data),
        .fifo_wr          (d2h_wr),
        .fifo_type        (d2h_wr_type),
        .fifo_data        (d2h_wr_data)
    );

    assign d2h_rd = d2h_valid && d2h_ready;      // host handshake

    fis_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) d2h_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .flush   (pcmd_st_cleared),
        .wr      (d2h_wr),
        .wr_data ({d2h_wr_type, d2h_wr_data}),
        .rd      (d2h_rd),
        .rd_data (d2h_rd_word),
        .nempty  (d2h_nempty),
        .fill    (d2h_fill)
    );

    assign d2h_type  = d2h_type_e'(d2h_rd_word[FIFO_WORD_W-1:32]);
    assign d2h_data  = d2h_rd_word[31:0];
    assign d2h_valid = d2h_nempty;
    assign d2h_many  = (d2h_fill >= MANY_V);

    // busy once free space drops under the link's in-flight margin
    assign d2h_free    = DEPTH_V - d2h_fill;
    assign ll_d2h_busy = (d2h_free < BUSY_V);

endmodule

// File: tb/tb_fis_checks.svh
// testbench helpers for the sata fis buffer
// payload LFSR, typed compare tasks and bounded wait tasks
`ifndef TB_FIS_CHECKS_SVH
`define TB_FIS_CHECKS_SVH

logic [15:0] lfsr_state = 16'd86;                // payload generator state

// fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic dword_t random_word();
    dword_t w;
    for (int b = 0; b < 32; b++) begin
        w[b] = lfsr_bit();
    end
    return w;
endfunction

// report a failure and stop the run
task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
endtask

task automatic check_dword(string name, dword_t exp, dword_t act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_h2d_type(string name, h2d_type_e exp, h2d_type_e act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
endtask

task automatic check_d2h_type(string name, d2h_type_e exp, d2h_type_e act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
endtask

task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    end
endtask

`endif

// File: tb/tb_sata_fis_buffer.sv
// testbench for the sata fis buffer
// table-driven h2d and d2h frames, fill flags and flush, with a small link model
`timescale 1ns/1ns

module tb_sata_fis_buffer import sata_fis_pkg::*;;

    localparam int FIFO_ADDR_W = 9;
    localparam int START_BITS  = 6;
    localparam int DEPTH       = 1 << FIFO_ADDR_W;
    localparam int TIMEOUT     = 200;            // cycles per wait

    localparam int DIR_H2D   = 0;
    localparam int DIR_D2H   = 1;
    localparam int DIR_FLAGS = 2;
    localparam int DIR_FLUSH = 3;

    logic      clk = 1'b0;
    logic      rst;
    dword_t    h2d_data;
    h2d_type_e h2d_type;
    logic      h2d_valid;
    logic      h2d_ready;
    dword_t    ll_h2d_data;
    logic      ll_h2d_last;
    logic      ll_h2d_valid;
    logic      ll_h2d_strobe;
    logic      ll_frame_req;
    logic      ll_frame_ack;
    dword_t    ll_d2h_data;
    logic      ll_d2h_valid;
    logic      ll_incom_start;
    logic      ll_incom_done;
    logic      ll_incom_invalidate;
    logic      ll_d2h_busy;
    dword_t    d2h_data;
    d2h_type_e d2h_type;
    logic      d2h_valid;
    logic      d2h_many;
    logic      d2h_ready;
    logic      pcmd_st_cleared;

    typedef struct {
        string name;
        int    dir;
        int    len;                              // FIS length in words
        bit    bad;                              // invalidate instead of done
        bit    early;                            // frame request before the last word
    } test_row_t;

    test_row_t rows [6];

    `include "tb_fis_checks.svh"

    sata_fis_buffer #(
        .FIFO_ADDR_W (FIFO_ADDR_W),
        .START_BITS  (START_BITS)
    ) dut_i (.*);

    always #20 clk = ~clk;                       // 40 ns period

    task automatic wait_frame_req(string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run({name, ": frame request never came"});
        end while (!ll_frame_req);
    endtask

    task automatic wait_d2h_valid(string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run({name, ": no word reached the host"});
        end while (!d2h_valid);
    endtask

    // host writes one FIS, link model acks and strobes it back out
    task automatic run_h2d(test_row_t r);
        dword_t q [$];
        int     req_at;
        req_at = -1;
        for (int i = 0; i < r.len; i++) begin
            q.push_back(random_word());
            @(negedge clk);
            if (ll_frame_req && req_at < 0) req_at = i;
            @(posedge clk);
            h2d_valid <= 1'b1;
            h2d_data  <= q[i];
            h2d_type  <= (i == 0) ? h2d_head :
                         (i == r.len - 1) ? h2d_last : sata_fis_pkg::h2d_data;
        end
        @(posedge clk);
        h2d_valid <= 1'b0;
        if (r.early) begin
            // fill trails the loop index by one, request one edge after the threshold
            check_dword({r.name, " req point"}, (1 << START_BITS) + 2, req_at);
        end else begin
            check_dword({r.name, " req point"}, 32'hffff_ffff, req_at);
        end
        wait_frame_req(r.name);
        @(posedge clk);
        ll_frame_ack <= 1'b1;
        @(posedge clk);
        ll_frame_ack <= 1'b0;
        for (int i = 0; i < r.len; i++) begin
            @(negedge clk);
            check_flag({r.name, " h2d valid"}, 1'b1, ll_h2d_valid);
            check_dword({r.name, " h2d data"}, q[i], ll_h2d_data);
            check_h2d_type({r.name, " h2d last"},
                           (i == r.len - 1) ? h2d_last : sata_fis_pkg::h2d_data,
                           ll_h2d_last ? h2d_last : sata_fis_pkg::h2d_data);
            @(posedge clk);
            ll_h2d_strobe <= 1'b1;
            @(posedge clk);
            ll_h2d_strobe <= 1'b0;
        end
        @(negedge clk);
        check_flag({r.name, " h2d drained"}, 1'b0, ll_h2d_valid);
        check_flag({r.name, " req dropped"}, 1'b0, ll_frame_req);
    endtask

    // link sends one frame, host reads it back with its marker
    task automatic run_d2h(test_row_t r);
        dword_t    q [$];
        d2h_type_e exp;
        @(posedge clk);
        ll_incom_start <= 1'b1;
        @(posedge clk);
        ll_incom_start <= 1'b0;
        for (int i = 0; i < r.len; i++) begin
            q.push_back(random_word());
            ll_d2h_valid <= 1'b1;
            ll_d2h_data  <= q[i];
            @(posedge clk);
        end
        ll_d2h_valid        <= 1'b0;
        ll_incom_done       <= !r.bad;
        ll_incom_invalidate <= r.bad;
        @(posedge clk);
        ll_incom_done       <= 1'b0;
        ll_incom_invalidate <= 1'b0;
        for (int i = 0; i <= r.len; i++) begin
            wait_d2h_valid(r.name);
            if (i == r.len) exp = r.bad ? d2h_err : d2h_ok;
            else if (i == 0) exp = d2h_fis_head;
            else exp = d2h_dma;
            check_d2h_type({r.name, " d2h type"}, exp, d2h_type);
            if (i < r.len) check_dword({r.name, " d2h data"}, q[i], d2h_data);
            @(posedge clk);
            d2h_ready <= 1'b1;
            @(posedge clk);
            d2h_ready <= 1'b0;
        end
        repeat (4) @(negedge clk);
        check_flag({r.name, " one marker"}, 1'b0, d2h_valid);
    endtask

    // fill both FIFOs with no reader until the flags trip
    task automatic run_flags(test_row_t r);
        int cnt;
        cnt = 0;
        @(posedge clk);
        ll_incom_start <= 1'b1;
        @(posedge clk);
        ll_incom_start <= 1'b0;
        do begin
            if (cnt > DEPTH) abort_run({r.name, ": link busy never asserted"});
            ll_d2h_valid <= 1'b1;
            ll_d2h_data  <= random_word();
            @(posedge clk);
            ll_d2h_valid <= 1'b0;
            cnt++;
            @(negedge clk);
            check_flag({r.name, " d2h many"}, cnt >= MANY_WORDS, d2h_many);
            @(posedge clk);
        end while (!ll_d2h_busy);
        check_dword({r.name, " busy fill"}, DEPTH - BUSY_MARGIN + 1, cnt);
        cnt = 0;
        while (h2d_ready) begin
            if (cnt > DEPTH) abort_run({r.name, ": host ready never dropped"});
            h2d_valid <= 1'b1;
            h2d_data  <= random_word();
            h2d_type  <= (cnt == 0) ? h2d_head : sata_fis_pkg::h2d_data;
            @(posedge clk);
            h2d_valid <= 1'b0;
            cnt++;
            @(negedge clk);
            @(posedge clk);
        end
        check_dword({r.name, " ready fill"}, DEPTH - MANY_WORDS, cnt);
    endtask

    task automatic run_flush(test_row_t r);
        @(negedge clk);
        check_flag({r.name, " d2h loaded"}, 1'b1, d2h_valid);
        check_flag({r.name, " h2d loaded"}, 1'b1, ll_h2d_valid);
        @(posedge clk);
        pcmd_st_cleared <= 1'b1;
        @(posedge clk);
        pcmd_st_cleared <= 1'b0;
        @(negedge clk);
        check_flag({r.name, " d2h valid"}, 1'b0, d2h_valid);
        check_flag({r.name, " h2d valid"}, 1'b0, ll_h2d_valid);
        check_flag({r.name, " h2d ready"}, 1'b1, h2d_ready);
    endtask

    initial begin
        rows[0] = '{"short_h2d", DIR_H2D, 5, 1'b0, 1'b0};
        rows[1] = '{"long_h2d", DIR_H2D, 100, 1'b0, 1'b1};
        rows[2] = '{"good_d2h", DIR_D2H, 6, 1'b0, 1'b0};
        rows[3] = '{"bad_d2h", DIR_D2H, 4, 1'b1, 1'b0};
        rows[4] = '{"fill_flags", DIR_FLAGS, 0, 1'b0, 1'b0};
        rows[5] = '{"flush", DIR_FLUSH, 0, 1'b0, 1'b0};

        rst                 = 1'b1;
        h2d_data            = '0;
        h2d_type            = sata_fis_pkg::h2d_data;
        h2d_valid           = 1'b0;
        ll_h2d_strobe       = 1'b0;
        ll_frame_ack        = 1'b0;
        ll_d2h_data         = '0;
        ll_d2h_valid        = 1'b0;
        ll_incom_start      = 1'b0;
        ll_incom_done       = 1'b0;
        ll_incom_invalidate = 1'b0;
        d2h_ready           = 1'b0;
        pcmd_st_cleared     = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("reset h2d ready", 1'b1, h2d_ready);
        check_flag("reset frame req", 1'b0, ll_frame_req);
        check_flag("reset d2h valid", 1'b0, d2h_valid);

        foreach (rows[i]) begin
            case (rows[i].dir)
                DIR_H2D:   run_h2d(rows[i]);
                DIR_D2H:   run_d2h(rows[i]);
                DIR_FLAGS: run_flags(rows[i]);
                default:   run_flush(rows[i]);
            endcase
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sata_fis_buffer.f
+incdir+tb
hw/sata_fis_pkg.sv
hw/fis_fifo.sv
hw/h2d_frame_starter.sv
hw/d2h_fis_tagger.sv
hw/sata_fis_buffer.sv
tb/tb_sata_fis_buffer.sv

// File: Makefile
TOP := tb_sata_fis_buffer

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

obj_dir/V$(TOP): sata_fis_buffer.f hw/*.sv tb/*.sv tb/*.svh
	verilator --binary --timing -Wall -f sata_fis_buffer.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
